// ==== hw/mem_pkg.sv ====
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [4:0]  reg_addr_t;
    // 0 is the most privileged level
    typedef logic [1:0]  plv_t;
    typedef logic [2:0]  acc_type_t;
    typedef logic [6:0]  excp_flags_t;

    // Access size encoding for rd_type and wr_type
    localparam acc_type_t ACC_BYTE = 3'd0;
    localparam acc_type_t ACC_HALF = 3'd1;
    localparam acc_type_t ACC_WORD = 3'd2;

    // Bit positions in excp_flags_t
    localparam int EXCP_PIL  = 6;
    localparam int EXCP_PIS  = 5;
    localparam int EXCP_PPI  = 4;
    localparam int EXCP_PME  = 3;
    localparam int EXCP_TLBR = 2;
    localparam int EXCP_ADEM = 1;
    localparam int EXCP_UP   = 0;

    typedef enum logic [3:0] {
        NOP,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        LL,
        SC
    } mem_op_t;

    typedef struct packed {
        logic exists;
        vpn_t vpn;
        ppn_t ppn;
        logic v;
        logic d;
        plv_t plv;
    } tlb_entry_t;

    typedef struct packed {
        logic found;
        ppn_t ppn;
        logic v;
        logic d;
        plv_t plv;
    } tlb_result_t;

    typedef struct packed {
        plv_t plv;
        logic trans_en;
    } mem_csr_t;

    typedef struct packed {
        logic      valid;
        mem_op_t   op;
        word_t     vaddr;
        word_t     store_data;
        logic      wreg;
        reg_addr_t waddr;
        word_t     wdata;
        logic      excp_in;
    } ex_mem_t;

    typedef struct packed {
        logic       ce;
        logic       we;
        word_t      addr;
        logic [3:0] sel;
        acc_type_t  rd_type;
        acc_type_t  wr_type;
        word_t      data;
    } dcache_req_t;

    typedef struct packed {
        logic        valid;
        mem_op_t     op;
        excp_flags_t excp;
        word_t       paddr;
        logic        mem_access_valid;
        logic        wreg;
        reg_addr_t   waddr;
        word_t       wdata;
        logic        ll_we;
        logic        ll_value;
    } mem1_mem2_t;

    typedef struct packed {
        logic      wreg;
        logic      data_ready;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

endpackage

// ==== hw/tlb_lookup.sv ====
`timescale 1ns/1ps

module tlb_lookup #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           rst,

    // Write port
    input  logic                           we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] idx_i,
    input  mem_pkg::tlb_entry_t            entry_i,

    // Lookup port
    input  mem_pkg::vpn_t                  vpn_i,
    output mem_pkg::tlb_result_t           result_o
);

    import mem_pkg::*;

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] hit;

    // Reset marks every entry as not existing
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i].exists <= 1'b0;
            end
        end else if (we_i) begin
            entries[idx_i] <= entry_i;
        end
    end

    // Parallel compare of every entry
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit[i] = entries[i].exists && (entries[i].vpn == vpn_i);
        end
    end

    // Walk down so the lowest matching index is the one left standing
    always_comb begin
        result_o = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                result_o.found = 1'b1;
                result_o.ppn   = entries[i].ppn;
                result_o.v     = entries[i].v;
                result_o.d     = entries[i].d;
                result_o.plv   = entries[i].plv;
            end
        end
    end

endmodule

// ==== hw/mem_csr.sv ====
`timescale 1ns/1ps

module mem_csr (
    input  logic              clk,
    input  logic              rst,

    // Configuration write port
    input  logic              csr_we_i,
    input  mem_pkg::mem_csr_t csr_i,

    // Link bit update from the stage
    input  logic              ll_wr_i,
    input  logic              ll_value_i,

    output mem_pkg::mem_csr_t csr_o,
    output logic              llbit_o
);

    import mem_pkg::*;

    mem_csr_t csr_q;
    logic     llbit_q;

    // Privilege level and translation enable
    always_ff @(posedge clk) begin
        if (rst) begin
            csr_q <= '0;
        end else if (csr_we_i) begin
            csr_q <= csr_i;
        end
    end

    // Link bit is set by LL and cleared by a successful SC
    always_ff @(posedge clk) begin
        if (rst) begin
            llbit_q <= 1'b0;
        end else if (ll_wr_i) begin
            llbit_q <= ll_value_i;
        end
    end

    assign csr_o   = csr_q;
    assign llbit_o = llbit_q;

endmodule

// ==== hw/mem1_stage.sv ====
`timescale 1ns/1ps

module mem1_stage (
    input  logic                 clk,
    input  logic                 rst,

    // Pipeline control
    input  logic                 flush_i,
    input  logic                 advance_i,
    output logic                 advance_ready_o,

    input  mem_pkg::ex_mem_t     ex_i,

    // TLB
    output mem_pkg::vpn_t        vpn_o,
    input  mem_pkg::tlb_result_t tlb_i,

    input  mem_pkg::mem_csr_t    csr_i,
    input  logic                 llbit_i,

    // Data cache
    output mem_pkg::dcache_req_t dcache_req_o,
    input  logic                 dcache_ready_i,
    input  logic                 dcache_ack_i,

    output mem_pkg::fwd_t        fwd_o,

    // Link bit write
    output logic                 ll_wr_o,
    output logic                 ll_value_o,

    output mem_pkg::mem1_mem2_t  mem2_o
);

    import mem_pkg::*;

    logic        is_load;
    logic        is_store;
    logic        access_mem;
    logic        check;
    logic        mem_access_valid;
    logic        need_cache;
    word_t       paddr;
    logic [1:0]  off;
    excp_flags_t excp;
    logic [3:0]  sel;
    acc_type_t   acc_type;
    word_t       st_data;
    mem1_mem2_t  mem2_d;

    assign is_load    = ex_i.op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
    assign is_store   = ex_i.op inside {ST_B, ST_H, ST_W, SC};
    assign access_mem = is_load | is_store;

    assign vpn_o = ex_i.vaddr[31:12];
    assign paddr = csr_i.trans_en ? {tlb_i.ppn, ex_i.vaddr[11:0]} : ex_i.vaddr;
    assign off   = paddr[1:0];

    // Exception checks only apply to mapped memory accesses
    assign check = csr_i.trans_en & access_mem;

    always_comb begin
        excp            = '0;
        excp[EXCP_TLBR] = check && !tlb_i.found;
        excp[EXCP_ADEM] = check && (csr_i.plv == 2'd3) && ex_i.vaddr[31];
        excp[EXCP_PIL]  = check && is_load && !tlb_i.v;
        excp[EXCP_PIS]  = check && is_store && !tlb_i.v;
        excp[EXCP_PPI]  = check && tlb_i.v && (csr_i.plv > tlb_i.plv);
        excp[EXCP_PME]  = check && is_store && tlb_i.v && (csr_i.plv <= tlb_i.plv) && !tlb_i.d;
        excp[EXCP_UP]   = ex_i.excp_in;
    end

    assign mem_access_valid = ex_i.valid && (excp == '0);

    // SC with the link bit clear never touches the cache
    assign need_cache = mem_access_valid && access_mem && !((ex_i.op == SC) && !llbit_i);

    // Byte lanes, size and lane aligned store data
    always_comb begin
        sel      = 4'b1111;
        acc_type = ACC_WORD;
        st_data  = ex_i.store_data;
        case (ex_i.op)
            LD_B, LD_BU, ST_B: begin
                sel      = 4'b0001 << off;
                acc_type = ACC_BYTE;
                st_data  = {24'b0, ex_i.store_data[7:0]} << {off, 3'b000};
            end
            LD_H, LD_HU, ST_H: begin
                sel      = 4'b0011 << off;
                acc_type = ACC_HALF;
                st_data  = {16'b0, ex_i.store_data[15:0]} << {off, 3'b000};
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        dcache_req_o = '0;
        if (need_cache && dcache_ready_i) begin
            dcache_req_o.ce   = 1'b1;
            dcache_req_o.addr = paddr;
            dcache_req_o.sel  = sel;
            if (is_store) begin
                dcache_req_o.we      = 1'b1;
                dcache_req_o.wr_type = acc_type;
                dcache_req_o.data    = st_data;
            end else begin
                dcache_req_o.rd_type = acc_type;
            end
        end
    end

    // Hold the pipeline until the cache acknowledges
    assign advance_ready_o = need_cache ? dcache_ack_i : 1'b1;

    // Next stage payload with the LL/SC outcome
    always_comb begin
        mem2_d.valid            = ex_i.valid;
        mem2_d.op               = ex_i.op;
        mem2_d.excp             = excp;
        mem2_d.paddr            = paddr;
        mem2_d.mem_access_valid = mem_access_valid;
        mem2_d.wreg             = ex_i.wreg;
        mem2_d.waddr            = ex_i.waddr;
        mem2_d.wdata            = ex_i.wdata;
        mem2_d.ll_we            = 1'b0;
        mem2_d.ll_value         = 1'b0;
        if (mem_access_valid) begin
            if (ex_i.op == LL) begin
                mem2_d.ll_we    = 1'b1;
                mem2_d.ll_value = 1'b1;
            end else if (ex_i.op == SC) begin
                // SC reports success in its destination
                mem2_d.wreg  = 1'b1;
                mem2_d.wdata = {31'b0, llbit_i};
                mem2_d.ll_we = llbit_i;
            end
        end
    end

    assign fwd_o.wreg       = mem2_d.wreg;
    assign fwd_o.data_ready = !is_load;
    assign fwd_o.waddr      = mem2_d.waddr;
    assign fwd_o.wdata      = mem2_d.wdata;

    // Link update only on the edge that loads the output register
    assign ll_wr_o    = mem2_d.ll_we && advance_i && !flush_i;
    assign ll_value_o = mem2_d.ll_value;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mem2_o <= '0;
        end else if (advance_i) begin
            mem2_o <= mem2_d;
        end
    end

endmodule

// ==== hw/mem_top.sv ====
`timescale 1ns/1ps

module mem_top #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           advance_i,
    input  logic                           flush_i,
    output logic                           advance_ready_o,

    input  mem_pkg::ex_mem_t               ex_i,

    // TLB fill
    input  logic                           tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_i,
    input  mem_pkg::tlb_entry_t            tlb_entry_i,

    // Configuration write
    input  logic                           csr_we_i,
    input  mem_pkg::mem_csr_t              csr_i,

    // Data cache
    output mem_pkg::dcache_req_t           dcache_req_o,
    input  logic                           dcache_ready_i,
    input  logic                           dcache_ack_i,

    output mem_pkg::fwd_t                  fwd_o,
    output mem_pkg::mem1_mem2_t            mem2_o
);

    import mem_pkg::*;

    vpn_t        vpn;
    tlb_result_t tlb_result;
    mem_csr_t    csr;
    logic        llbit;
    logic        ll_wr;
    logic        ll_value;

    tlb_lookup #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_tlb (
        .clk      (clk),
        .rst      (rst),
        .we_i     (tlb_we_i),
        .idx_i    (tlb_idx_i),
        .entry_i  (tlb_entry_i),
        .vpn_i    (vpn),
        .result_o (tlb_result)
    );

    mem_csr i_csr (
        .clk        (clk),
        .rst        (rst),
        .csr_we_i   (csr_we_i),
        .csr_i      (csr_i),
        .ll_wr_i    (ll_wr),
        .ll_value_i (ll_value),
        .csr_o      (csr),
        .llbit_o    (llbit)
    );

    mem1_stage i_mem1 (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .advance_i       (advance_i),
        .advance_ready_o (advance_ready_o),
        .ex_i            (ex_i),
        .vpn_o           (vpn),
        .tlb_i           (tlb_result),
        .csr_i           (csr),
        .llbit_i         (llbit),
        .dcache_req_o    (dcache_req_o),
        .dcache_ready_i  (dcache_ready_i),
        .dcache_ack_i    (dcache_ack_i),
        .fwd_o           (fwd_o),
        .ll_wr_o         (ll_wr),
        .ll_value_o      (ll_value),
        .mem2_o          (mem2_o)
    );

endmodule

// ==== verification/mem_ref_model.svh ====
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// Model copies of the TLB, configuration and link bit
tlb_entry_t ref_tlb [TLB_ENTRIES];
mem_csr_t   ref_csr;
logic       ref_llbit;

function automatic tlb_result_t find_entry(vpn_t vpn);
    tlb_result_t r;
    r = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        if (ref_tlb[i].exists && ref_tlb[i].vpn == vpn) begin
            r.found = 1'b1;
            r.ppn   = ref_tlb[i].ppn;
            r.v     = ref_tlb[i].v;
            r.d     = ref_tlb[i].d;
            r.plv   = ref_tlb[i].plv;
            return r;
        end
    end
    return r;
endfunction

function automatic logic op_loads(mem_op_t op);
    return op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
endfunction

function automatic logic op_stores(mem_op_t op);
    return op inside {ST_B, ST_H, ST_W, SC};
endfunction

function automatic word_t translate_addr(ex_mem_t ex);
    tlb_result_t t;
    t = find_entry(ex.vaddr[31:12]);
    if (!ref_csr.trans_en) begin
        return ex.vaddr;
    end
    return {t.ppn, ex.vaddr[11:0]};
endfunction

function automatic excp_flags_t excp_flags(ex_mem_t ex);
    tlb_result_t t;
    excp_flags_t e;
    logic        ld;
    logic        st;
    t  = find_entry(ex.vaddr[31:12]);
    ld = op_loads(ex.op);
    st = op_stores(ex.op);
    e  = '0;
    if (ref_csr.trans_en && (ld || st)) begin
        e[EXCP_TLBR] = !t.found;
        e[EXCP_ADEM] = (ref_csr.plv == 2'd3) && ex.vaddr[31];
        e[EXCP_PIL]  = ld && !t.v;
        e[EXCP_PIS]  = st && !t.v;
        e[EXCP_PPI]  = t.v && (ref_csr.plv > t.plv);
        e[EXCP_PME]  = st && t.v && (ref_csr.plv <= t.plv) && !t.d;
    end
    e[EXCP_UP] = ex.excp_in;
    return e;
endfunction

function automatic logic access_clean(ex_mem_t ex);
    return ex.valid && (excp_flags(ex) == '0);
endfunction

// A failed SC stays away from the cache
function automatic logic cache_needed(ex_mem_t ex);
    logic mem_op;
    mem_op = op_loads(ex.op) || op_stores(ex.op);
    return access_clean(ex) && mem_op && !((ex.op == SC) && !ref_llbit);
endfunction

function automatic dcache_req_t build_req(ex_mem_t ex, logic ready);
    dcache_req_t r;
    word_t       pa;
    logic [1:0]  off;
    acc_type_t   size;
    r    = '0;
    pa   = translate_addr(ex);
    off  = pa[1:0];
    if (cache_needed(ex) && ready) begin
        r.ce   = 1'b1;
        r.we   = op_stores(ex.op);
        r.addr = pa;
        case (ex.op)
            LD_B, LD_BU, ST_B: begin
                r.sel  = 4'b0001 << off;
                size   = ACC_BYTE;
                r.data = {24'b0, ex.store_data[7:0]} << (8 * off);
            end
            LD_H, LD_HU, ST_H: begin
                r.sel  = 4'b0011 << off;
                size   = ACC_HALF;
                r.data = {16'b0, ex.store_data[15:0]} << (8 * off);
            end
            default: begin
                r.sel  = 4'b1111;
                size   = ACC_WORD;
                r.data = ex.store_data;
            end
        endcase
        if (r.we) begin
            r.wr_type = size;
        end else begin
            r.rd_type = size;
            r.data    = '0;
        end
    end
    return r;
endfunction

function automatic mem1_mem2_t next_mem2(ex_mem_t ex);
    mem1_mem2_t m;
    m.valid            = ex.valid;
    m.op               = ex.op;
    m.excp             = excp_flags(ex);
    m.paddr            = translate_addr(ex);
    m.mem_access_valid = access_clean(ex);
    m.wreg             = ex.wreg;
    m.waddr            = ex.waddr;
    m.wdata            = ex.wdata;
    m.ll_we            = 1'b0;
    m.ll_value         = 1'b0;
    if (m.mem_access_valid && ex.op == LL) begin
        m.ll_we    = 1'b1;
        m.ll_value = 1'b1;
    end
    if (m.mem_access_valid && ex.op == SC) begin
        m.wreg  = 1'b1;
        m.wdata = word_t'(ref_llbit);
        m.ll_we = ref_llbit;
    end
    return m;
endfunction

`endif

// ==== verification/mem_tb.sv ====
`timescale 1ns/1ps

module mem_tb;

    import mem_pkg::*;

    localparam int TLB_ENTRIES = 8;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    localparam int NUM_INSTR   = 3000;
    localparam int HOLD_LIMIT  = 64;

    logic                 clk;
    logic                 rst;
    logic                 advance_i;
    logic                 flush_i;
    logic                 advance_ready_o;
    ex_mem_t              ex_i;
    logic                 tlb_we_i;
    logic [IDX_W-1:0]     tlb_idx_i;
    tlb_entry_t           tlb_entry_i;
    logic                 csr_we_i;
    mem_csr_t             csr_i;
    dcache_req_t          dcache_req_o;
    logic                 dcache_ready_i;
    logic                 dcache_ack_i;
    fwd_t                 fwd_o;
    mem1_mem2_t           mem2_o;

    vpn_t                 vpn_pool [8];
    ex_mem_t              cur;
    mem1_mem2_t           exp_mem2;
    mem1_mem2_t           nxt;
    dcache_req_t          exp_req;
    fwd_t                 exp_fwd;
    logic                 adv_ok;
    int                   served;
    int                   delay;
    int                   wait_cycles;
    logic                 done;

    `include "mem_ref_model.svh"

    mem_top #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .advance_i       (advance_i),
        .flush_i         (flush_i),
        .advance_ready_o (advance_ready_o),
        .ex_i            (ex_i),
        .tlb_we_i        (tlb_we_i),
        .tlb_idx_i       (tlb_idx_i),
        .tlb_entry_i     (tlb_entry_i),
        .csr_we_i        (csr_we_i),
        .csr_i           (csr_i),
        .dcache_req_o    (dcache_req_o),
        .dcache_ready_i  (dcache_ready_i),
        .dcache_ack_i    (dcache_ack_i),
        .fwd_o           (fwd_o),
        .mem2_o          (mem2_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
        assert (actual === expected)
            else stop_run($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic ex_mem_t random_instr();
        ex_mem_t e;
        e.valid = ($urandom_range(9) != 0);
        e.op    = mem_op_t'(4'($urandom_range(10)));
        e.vaddr = $urandom;
        // Mostly hit the pool so the TLB gets exercised
        if ($urandom_range(7) != 0) begin
            e.vaddr[31:12] = vpn_pool[3'($urandom)];
        end
        e.store_data = $urandom;
        e.wreg       = 1'($urandom);
        e.waddr      = reg_addr_t'($urandom);
        e.wdata      = $urandom;
        e.excp_in    = ($urandom_range(15) == 0);
        return e;
    endfunction

    task automatic fill_tlb();
        tlb_entry_t e;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            @(negedge clk);
            e.exists    = ($urandom_range(3) != 0);
            e.vpn       = vpn_pool[3'($urandom)];
            e.ppn       = ppn_t'($urandom);
            e.v         = ($urandom_range(7) != 0);
            e.d         = 1'($urandom);
            e.plv       = plv_t'($urandom);
            tlb_we_i    = 1'b1;
            tlb_idx_i   = IDX_W'(i);
            tlb_entry_i = e;
            ref_tlb[i]  = e;
        end
        @(negedge clk);
        tlb_we_i = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h0391_0347));
        rst            = 1'b1;
        advance_i      = 1'b0;
        flush_i        = 1'b0;
        ex_i           = '0;
        tlb_we_i       = 1'b0;
        tlb_idx_i      = '0;
        tlb_entry_i    = '0;
        csr_we_i       = 1'b0;
        csr_i          = '0;
        dcache_ready_i = 1'b0;
        dcache_ack_i   = 1'b0;
        ref_csr        = '0;
        ref_llbit      = 1'b0;
        exp_mem2       = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            ref_tlb[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            vpn_pool[i] = vpn_t'($urandom);
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fill_tlb();

        for (int n = 0; n < NUM_INSTR; n++) begin
            cur         = random_instr();
            served      = 0;
            delay       = $urandom_range(3);
            wait_cycles = 0;
            done        = 1'b0;
            while (!done) begin
                @(negedge clk);
                check_value("mem2", 128'(exp_mem2), 128'(mem2_o));
                ex_i           = cur;
                csr_we_i       = ($urandom_range(15) == 0);
                csr_i.plv      = plv_t'($urandom);
                csr_i.trans_en = ($urandom_range(3) != 0);
                dcache_ready_i = ($urandom_range(3) != 0);
                // Ack comes once the request has been out for delay cycles
                dcache_ack_i   = dcache_ready_i && (served >= delay);
                flush_i        = ($urandom_range(31) == 0);
                adv_ok         = cache_needed(cur) ? dcache_ack_i : 1'b1;
                advance_i      = adv_ok && ($urandom_range(3) != 0);
                #1;
                exp_req            = build_req(cur, dcache_ready_i);
                nxt                = next_mem2(cur);
                exp_fwd.wreg       = nxt.wreg;
                exp_fwd.data_ready = !op_loads(cur.op);
                exp_fwd.waddr      = nxt.waddr;
                exp_fwd.wdata      = nxt.wdata;
                check_value("request", 128'(exp_req), 128'(dcache_req_o));
                check_value("advance_ready", 128'(adv_ok), 128'(advance_ready_o));
                check_value("forward", 128'(exp_fwd), 128'(fwd_o));

                // Model state after the coming rising edge
                if (flush_i) begin
                    exp_mem2 = '0;
                end else if (advance_i) begin
                    exp_mem2 = nxt;
                    if (nxt.ll_we) begin
                        ref_llbit = nxt.ll_value;
                    end
                end
                if (csr_we_i) begin
                    ref_csr = csr_i;
                end
                if (exp_req.ce) begin
                    served++;
                end
                done = advance_i || flush_i;
                wait_cycles++;
                if (!done && wait_cycles > HOLD_LIMIT) begin
                    stop_run($sformatf("Timeout: instruction %0d was not accepted in %0d cycles",
                                       n, HOLD_LIMIT));
                end
            end
        end

        @(negedge clk);
        check_value("mem2", 128'(exp_mem2), 128'(mem2_o));
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verification
hw/mem_pkg.sv
hw/tlb_lookup.sv
hw/mem_csr.sv
hw/mem1_stage.sv
hw/mem_top.sv
verification/mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module mem_tb -f build.f; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vmem_tb 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
